// File: bench/invAesCases.txt
// Columns: key, cyphertext, expected plaintext. 128-bit hex each, FIPS-197 byte order.
// The first line must stay FIPS-197 C.1, since it is also the latency test.
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710
00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000
00000000000000000000000000000000 0336763e966d92595a567cc9ce537f5e f34481ec3cc627bacd5dc3fb08f273e6

// File: bench/invAesTb.sv
/* Testbench for the AES-128 decryption core. It runs the vectors from the case
   file as an isolated job, back to back, with ignored busy starts and with random gaps. */
`timescale 1ns/1ps

module invAesTb;

  localparam int maxCases   = 32;
  localparam int expLatency = 25; // Start to done with no contention.

  logic         clk;
  logic         rstN;
  logic         start;
  logic [127:0] key;
  logic [127:0] cyphertext;
  logic         ready;
  logic         done;
  logic [127:0] plaintext;

  logic [127:0] vectors [0:3*maxCases-1]; // Key, cyphertext and plaintext per case.
  logic [127:0] expQ [$];                 // Expected plaintexts in start order.
  logic [127:0] expected;
  logic [127:0] lastPlain;                // Result that must hold until the next done.
  logic         havePlain     = 1'b0;
  logic [7:0]   lfsr          = 8'd19;
  int           numCases      = -1;       // Set once the case file is read.
  int           errors        = 0;
  int           checks        = 0;
  int           acceptedCount = 0;
  int           doneCount     = 0;

  tbClock clockGen (.clk(clk), .rstN(rstN));

  invAesCore DUT (
    .clk        (clk),
    .rstN       (rstN),
    .start      (start),
    .key        (key),
    .cyphertext (cyphertext),
    .ready      (ready),
    .done       (done),
    .plaintext  (plaintext)
  );

  // Stand-in for entries the case file leaves empty. It differs at every address.
  function automatic logic [127:0] fillWord(input int idx);
    return {4{32'(idx) ^ 32'h6b8b4567}};
  endfunction

  // Galois LFSR with taps for x^8+x^6+x^5+x^4+1. One step per bit drawn.
  task automatic drawBits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | lfsr[0];
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 8'hb8) : (lfsr >> 1);
    end
  endtask

  // Called at a falling edge with ready high. The strobe drops at the next edge.
  task automatic issueCase(input int idx);
    start      = 1'b1;
    key        = vectors[3*idx];
    cyphertext = vectors[3*idx+1];
    expQ.push_back(vectors[3*idx+2]);
    acceptedCount++;
    @(negedge clk);
    start = 1'b0;
  endtask

  // Waits for ready. With strobeBusy set, every busy cycle carries a start with junk data.
  task automatic waitReady(input bit strobeBusy);
    int guard;
    guard = 0;
    while (!ready && guard < 200) begin
      start      = strobeBusy;
      key        = ~key; // Junk that would corrupt results if a busy start got in.
      cyphertext = {cyphertext[63:0], cyphertext[127:64]};
      @(negedge clk);
      guard++;
    end
    start = 1'b0;
    if (!ready) begin
      $display("ready stayed low for %0d cycles at %0d ns.", guard, $time);
      errors++;
    end
  endtask

  // Waits until every accepted job has produced its done.
  task automatic drain();
    int guard;
    guard = 0;
    while (doneCount < acceptedCount && guard < 400) begin
      @(posedge clk);
      guard++;
    end
    if (doneCount < acceptedCount) begin
      $display("%0d jobs never finished by %0d ns.", acceptedCount - doneCount, $time);
      errors++;
    end
    @(negedge clk);
  endtask

  // Result monitor. Outputs are sampled on the falling edge, away from clk.
  always @(negedge clk) begin
    if (rstN) begin
      if (done) begin
        doneCount++;
        if (expQ.size() == 0) begin
          $display("done pulsed at %0d ns with no job outstanding.", $time);
          errors++;
        end else begin
          expected = expQ.pop_front(); // Results leave in start order.
          checks++;
          if (plaintext !== expected) begin
            $display("** Error at %0d ns: plaintext expected %h, got %h",
                     $time, expected, plaintext);
            errors++;
          end
        end
        lastPlain = plaintext;
        havePlain = 1'b1;
      end else if (havePlain) begin
        checks++;
        if (plaintext !== lastPlain) begin // Must hold between done strobes.
          $display("** Error at %0d ns: plaintext expected %h, got %h",
                   $time, lastPlain, plaintext);
          errors++;
        end
      end
    end
  end

  initial begin
    int n;
    int lat;
    int gap;
    start      = 1'b0;
    key        = '0;
    cyphertext = '0;
    for (int i = 0; i < 3 * maxCases; i++) begin
      vectors[i] = fillWord(i);
    end
    $readmemh("bench/invAesCases.txt", vectors);
    n = 0;
    while (n < maxCases && vectors[3*n] !== fillWord(3*n)) n++; // Unread entries keep the fill.
    numCases = n;
    if (numCases == 0) begin
      $display("No cases could be read from bench/invAesCases.txt.");
      errors++;
    end
    wait (rstN === 1'b1);

    // Idle after reset. Nothing has started yet.
    repeat (4) begin
      @(negedge clk);
      checks++;
      if (ready !== 1'b1) begin
        $display("** Error at %0d ns: ready expected 1, got %b", $time, ready);
        errors++;
      end
      if (done !== 1'b0) begin
        $display("** Error at %0d ns: done expected 0, got %b", $time, done);
        errors++;
      end
    end

    if (numCases > 0) begin
      // Case 0 is FIPS-197 C.1, run alone to measure the latency.
      issueCase(0);
      lat = 1;
      while (!done && lat < 4 * expLatency) begin
        @(negedge clk);
        lat++;
      end
      checks++;
      if (!done) begin
        $display("No done within %0d cycles of the C.1 start.", lat);
        errors++;
      end else if (lat != expLatency) begin
        $display("** Error at %0d ns: done latency expected %0d, got %0d",
                 $time, expLatency, lat);
        errors++;
      end
      drain();

      // Back to back, as fast as ready allows. This makes the two jobs overlap.
      for (int i = 0; i < numCases; i++) begin
        waitReady(1'b0);
        issueCase(i);
      end
      drain();

      // Same again with starts hammered in while busy. Those must be dropped.
      for (int i = 0; i < numCases; i++) begin
        waitReady(1'b1);
        issueCase(i);
      end
      waitReady(1'b1);
      drain();

      // Random idle gaps of 0 to 7 cycles.
      for (int i = 0; i < numCases; i++) begin
        waitReady(1'b0);
        drawBits(3, gap);
        repeat (gap) @(negedge clk);
        issueCase(i);
      end
      drain();
    end

    checks++;
    if (doneCount != acceptedCount) begin
      $display("** Error at %0d ns: done count expected %0d, got %0d",
               $time, acceptedCount, doneCount);
      errors++;
    end
    if (expQ.size() != 0) begin
      $display("%0d expected results were never produced.", expQ.size());
      errors++;
    end
    $display("Checks: %0d, errors: %0d, jobs accepted: %0d, done strobes: %0d",
             checks, errors, acceptedCount, doneCount);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog. It allows 40 cycles per job, over all four runs, plus two spare jobs.
  initial begin
    wait (numCases >= 0);
    repeat ((3 * numCases + 3) * 40) @(posedge clk);
    $display("Run timed out at %0d ns with %0d jobs outstanding.",
             $time, acceptedCount - doneCount);
    $display("Errors found");
    $finish;
  end

endmodule

// File: bench/tbClock.sv
/* Testbench clock and reset. A 10 ns clock, with reset held low for the
   first four cycles. */
`timescale 1ns/1ps

module tbClock #(
  parameter int halfPeriod  = 5, // Half of the 10 ns period.
  parameter int resetCycles = 4
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    rstN = 1'b0; // Asserted from time zero.
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1; // Released between edges, like every other input.
  end

endmodule

// File: include/aes_settings.svh
/* AES-128 decryption settings. Round count, number of round-key banks and
   the widths of the round-key memory address. */
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// AES-128 runs ten rounds, so each bank holds eleven round keys.
`define AES_ROUNDS 10

// Two banks let one job decrypt while the next job's key is expanded.
`define KEY_BANKS 2

// Width of a round index. It must reach AES_ROUNDS.
`define ROUND_BITS 4

// Width of a bank index.
`define BANK_BITS 1

`endif

// File: verilog/aesPkg.sv
/* AES package. Block, address and job types, plus the GF(2^8) arithmetic
   behind the S-boxes, the key-expansion helpers and the inverse round steps. */
`include "aes_settings.svh"

package aesPkg;

  typedef logic [127:0] blockT; // FIPS-197 column layout with word 0 in bits 127:96.

  typedef struct packed {
    logic [`BANK_BITS-1:0]  bank;
    logic [`ROUND_BITS-1:0] round;
  } keyAddrT;

  typedef struct packed {
    blockT                 block; // Cyphertext still to be decrypted.
    logic [`BANK_BITS-1:0] bank;  // Bank that holds this job's round keys.
  } cipherJobT;

  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00); // Multiply by x mod the AES polynomial.
  endfunction

  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) acc ^= p; // Shift-and-add over the bits of b.
      p = xtime(p);
    end
    return acc;
  endfunction

  // The inverse is a^254, the product of the squares a^2 up to a^128.
  // Zero comes out as zero, as the S-box needs.
  function automatic logic [7:0] gfInv(input logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] acc;
    sq  = a;
    acc = 8'h01;
    for (int i = 1; i < 8; i++) begin
      sq  = gfMul(sq, sq);
      acc = gfMul(acc, sq);
    end
    return acc;
  endfunction

  function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
    logic [15:0] dbl;
    dbl = {x, x};
    return dbl[15-n -: 8]; // Rotate left by n bits.
  endfunction

  function automatic logic [7:0] sbox(input logic [7:0] a);
    logic [7:0] b;
    b = gfInv(a);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
  endfunction

  // The inverse affine map comes first, then the field inverse.
  function automatic logic [7:0] invSbox(input logic [7:0] a);
    return gfInv(rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05);
  endfunction

  function automatic logic [31:0] subWord(input logic [31:0] w);
    return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
  endfunction

  function automatic logic [31:0] rotWord(input logic [31:0] w);
    return {w[23:0], w[31:24]};
  endfunction

  // Round constant for key round 1 to 10, in the top byte of the word.
  function automatic logic [31:0] rcon(input logic [`ROUND_BITS-1:0] round);
    logic [7:0] rc;
    rc = 8'h01;
    for (int i = 2; i <= `AES_ROUNDS; i++) begin
      if (round >= i) rc = xtime(rc);
    end
    return {rc, 24'h000000};
  endfunction

  function automatic blockT invShiftRows(input blockT s);
    blockT o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[127-8*(4*c+r) -: 8] = s[127-8*(4*((c+4-r)%4)+r) -: 8]; // Row r moves right by r.
      end
    end
    return o;
  endfunction

  function automatic blockT invSubBytes(input blockT s);
    blockT o;
    for (int i = 0; i < 16; i++) begin
      o[8*i +: 8] = invSbox(s[8*i +: 8]);
    end
    return o;
  endfunction

  function automatic blockT invMixColumns(input blockT s);
    blockT      o;
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      a0 = s[127-32*c -: 8]; // Top byte of column c.
      a1 = s[119-32*c -: 8];
      a2 = s[111-32*c -: 8];
      a3 = s[103-32*c -: 8];
      o[127-32*c -: 8] = gfMul(a0, 8'h0e) ^ gfMul(a1, 8'h0b)
                       ^ gfMul(a2, 8'h0d) ^ gfMul(a3, 8'h09);
      o[119-32*c -: 8] = gfMul(a0, 8'h09) ^ gfMul(a1, 8'h0e)
                       ^ gfMul(a2, 8'h0b) ^ gfMul(a3, 8'h0d);
      o[111-32*c -: 8] = gfMul(a0, 8'h0d) ^ gfMul(a1, 8'h09)
                       ^ gfMul(a2, 8'h0e) ^ gfMul(a3, 8'h0b);
      o[103-32*c -: 8] = gfMul(a0, 8'h0b) ^ gfMul(a1, 8'h0d)
                       ^ gfMul(a2, 8'h09) ^ gfMul(a3, 8'h0e);
    end
    return o;
  endfunction

endpackage

// File: verilog/invAesCore.sv
/* AES-128 decryption core. The key scheduler and the inverse cipher share a
   two-bank round-key store, so two jobs can be in flight at once. */
`timescale 1ns/1ps

module invAesCore (
  input  logic         clk,
  input  logic         rstN,
  input  logic         start,
  input  logic [127:0] key,
  input  logic [127:0] cyphertext,
  output logic         ready,
  output logic         done,
  output logic [127:0] plaintext
);

  logic              keysReady; // Expansion finished for the job below.
  aesPkg::cipherJobT job;

  keyMemBus schedBus ();
  keyMemBus cipherBus ();

  keyScheduler scheduler (
    .clk        (clk),
    .rstN       (rstN),
    .start      (start),
    .key        (key),
    .cyphertext (cyphertext),
    .ready      (ready),
    .keysReady  (keysReady),
    .job        (job),
    .mem        (schedBus.requester)
  );

  invCipher cipher (
    .clk       (clk),
    .rstN      (rstN),
    .keysReady (keysReady),
    .job       (job),
    .mem       (cipherBus.requester),
    .done      (done),
    .plaintext (plaintext)
  );

  roundKeyStore store (
    .clk        (clk),
    .rstN       (rstN),
    .cipherPort (cipherBus.arbiter),
    .schedPort  (schedBus.arbiter)
  );

endmodule

// File: verilog/invCipher.sv
/* AES-128 inverse cipher. Reads a job's round keys from 10 down to 0 and
   applies one inverse round per key to recover the plaintext. */
`timescale 1ns/1ps
`include "aes_settings.svh"

module invCipher (
  input  logic              clk,
  input  logic              rstN,
  input  logic              keysReady,
  input  aesPkg::cipherJobT job,
  keyMemBus.requester       mem,
  output logic              done,
  output aesPkg::blockT     plaintext
);

  logic                   issuing;   // Reads still to be issued.
  logic [`ROUND_BITS-1:0] readRound; // Round of the next read.
  logic [`BANK_BITS-1:0]  bank;      // Bank of the job in progress.
  logic                   rdValid;   // A round key is on rdata this cycle.
  logic [`ROUND_BITS-1:0] rdRound;   // Round of that key.
  aesPkg::blockT          state;
  aesPkg::blockT          invStep;   // Inverse shift and substitution with the key added.
  logic                   firstKey;
  logic                   lastKey;

  assign firstKey = rdRound == `ROUND_BITS'(`AES_ROUNDS);
  assign lastKey  = rdRound == '0;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      issuing   <= 1'b0;
      readRound <= '0;
      bank      <= '0;
      rdValid   <= 1'b0;
      rdRound   <= '0;
      done      <= 1'b0;
    end else begin
      rdValid <= issuing && mem.gnt;
      done    <= rdValid && lastKey; // Pulses as plaintext is loaded.
      if (keysReady) begin
        issuing   <= 1'b1;
        readRound <= `ROUND_BITS'(`AES_ROUNDS); // Keys are taken in reverse order.
        bank      <= job.bank;
      end else if (issuing && mem.gnt) begin
        rdRound <= readRound;
        if (readRound == '0) begin
          issuing <= 1'b0;
        end else begin
          readRound <= readRound - `ROUND_BITS'(1);
        end
      end
    end
  end

  assign invStep = aesPkg::invSubBytes(aesPkg::invShiftRows(state)) ^ mem.rdata;

  always_ff @(posedge clk) begin
    if (keysReady) begin
      state <= job.block;
    end else if (rdValid) begin
      if (firstKey) begin
        state <= state ^ mem.rdata; // Round key 10 is only added.
      end else if (!lastKey) begin
        state <= aesPkg::invMixColumns(invStep);
      end else begin
        plaintext <= invStep; // The last round skips the column mix.
      end
    end
  end

  assign mem.req   = issuing;
  assign mem.we    = 1'b0;
  assign mem.addr  = '{bank: bank, round: readRound};
  assign mem.wdata = '0;

  // The scheduler's stall behind these reads keeps the next job away until this one is done.
  noOverrun: assert property (@(posedge clk) disable iff (!rstN)
    keysReady |-> !(issuing || rdValid))
    else $error("Round keys arrived while the cipher was busy.");

endmodule

// File: verilog/keyMemBus.sv
/* Round-key memory bus. One requester's port with a same-cycle grant and
   read data that arrives one cycle after a granted read. */
`timescale 1ns/1ps

interface keyMemBus;

  logic            req;   // Held with its fields until gnt is seen.
  logic            we;    // High for a write, low for a read.
  aesPkg::keyAddrT addr;
  aesPkg::blockT   wdata;
  logic            gnt;   // The access completes in the cycle gnt is high.
  aesPkg::blockT   rdata; // Valid in the cycle after a granted read.

  // The requester side drives the request and its fields.
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  // The memory side answers with the grant and the read data.
  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

// File: verilog/keyScheduler.sv
/* AES-128 key scheduler. Takes a job on start, writes round keys 0 to 10
   into the next free bank and hands the job to the inverse cipher. */
`timescale 1ns/1ps
`include "aes_settings.svh"

module keyScheduler (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  aesPkg::blockT     key,
  input  aesPkg::blockT     cyphertext,
  output logic              ready,
  output logic              keysReady,
  output aesPkg::cipherJobT job,
  keyMemBus.requester       mem
);

  logic                   busy;     // Expansion in progress.
  logic [`ROUND_BITS-1:0] round;    // Round key being written.
  logic [`BANK_BITS-1:0]  curBank;  // Bank of the job in progress.
  logic [`BANK_BITS-1:0]  nextBank; // Bank the next job will use.
  aesPkg::blockT          roundKey; // Current round key.
  aesPkg::blockT          nextKey;  // Round key that follows it.
  aesPkg::blockT          blockQ;   // Cyphertext travelling with the job.
  logic [31:0]            temp;
  logic                   accept;
  logic                   lastWrite;

  assign ready     = !busy;
  assign accept    = start && !busy; // A start while busy is dropped.
  assign lastWrite = busy && mem.gnt && (round == `ROUND_BITS'(`AES_ROUNDS));

  // One step of the forward expansion. Each word folds in the word before it.
  assign temp = aesPkg::subWord(aesPkg::rotWord(roundKey[31:0]))
              ^ aesPkg::rcon(round + `ROUND_BITS'(1));
  assign nextKey[127:96] = roundKey[127:96] ^ temp;
  assign nextKey[95:64]  = roundKey[95:64]  ^ nextKey[127:96];
  assign nextKey[63:32]  = roundKey[63:32]  ^ nextKey[95:64];
  assign nextKey[31:0]   = roundKey[31:0]   ^ nextKey[63:32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy      <= 1'b0;
      round     <= '0;
      curBank   <= '0;
      nextBank  <= '0;
      keysReady <= 1'b0;
    end else begin
      keysReady <= lastWrite; // One-cycle strobe after round 10 is written.
      if (accept) begin
        busy     <= 1'b1;
        round    <= '0;
        curBank  <= nextBank;
        nextBank <= (nextBank == `BANK_BITS'(`KEY_BANKS - 1)) ? '0
                                                             : nextBank + `BANK_BITS'(1);
      end else if (lastWrite) begin
        busy <= 1'b0;
      end else if (busy && mem.gnt) begin
        round <= round + `ROUND_BITS'(1); // Advance only when the write went in.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      roundKey <= key; // Round key 0 is the cipher key itself.
      blockQ   <= cyphertext;
    end else if (busy && mem.gnt) begin
      roundKey <= nextKey;
    end
  end

  assign mem.req   = busy;
  assign mem.we    = 1'b1; // The scheduler only writes.
  assign mem.addr  = '{bank: curBank, round: round};
  assign mem.wdata = roundKey;

  // The registers stay put until the next accepted start, so job is still valid at keysReady.
  assign job = '{block: blockQ, bank: curBank};

  roundBound: assert property (@(posedge clk) disable iff (!rstN)
    busy |-> round <= `AES_ROUNDS)
    else $error("Key round %0d passed the last round.", round);

endmodule

// File: verilog/roundKeyStore.sv
/* Round-key store. Two banks of eleven round keys behind a fixed-priority
   arbiter that always serves the inverse cipher ahead of the key scheduler. */
`timescale 1ns/1ps
`include "aes_settings.svh"

module roundKeyStore (
  input logic       clk,
  input logic       rstN,
  keyMemBus.arbiter cipherPort,
  keyMemBus.arbiter schedPort
);

  aesPkg::blockT   keys [`KEY_BANKS][`AES_ROUNDS+1]; // Indexed by bank, then round.
  aesPkg::blockT   rdataQ;   // Registered read data shared by both ports.
  aesPkg::keyAddrT selAddr;  // Address of the granted request.
  aesPkg::blockT   selWdata;
  logic            selWe;
  logic            anyGnt;

  // The cipher wins every cycle it asks. The scheduler waits until it stops.
  assign cipherPort.gnt = cipherPort.req;
  assign schedPort.gnt  = schedPort.req && !cipherPort.req;
  assign anyGnt         = cipherPort.req || schedPort.req;

  // The winner steers the single memory port.
  assign selAddr  = cipherPort.req ? cipherPort.addr  : schedPort.addr;
  assign selWdata = cipherPort.req ? cipherPort.wdata : schedPort.wdata;
  assign selWe    = cipherPort.req ? cipherPort.we    : schedPort.we;

  always_ff @(posedge clk) begin
    if (anyGnt) begin
      if (selWe) begin
        keys[selAddr.bank][selAddr.round] <= selWdata;
      end else begin
        rdataQ <= keys[selAddr.bank][selAddr.round]; // Lands one cycle after the grant.
      end
    end
  end

  // Only the port granted last cycle looks at the read data.
  assign cipherPort.rdata = rdataQ;
  assign schedPort.rdata  = rdataQ;

  // A refused scheduler request waits with its address and data unchanged.
  schedHolds: assert property (@(posedge clk) disable iff (!rstN)
    schedPort.req && !schedPort.gnt |=> schedPort.req && $stable(schedPort.addr)
      && $stable(schedPort.wdata))
    else $error("Scheduler request changed while it was stalled.");

  // The cipher only ever reads the keys the scheduler left behind.
  cipherReadsOnly: assert property (@(posedge clk) disable iff (!rstN)
    cipherPort.req |-> !cipherPort.we)
    else $error("Write request on the cipher port.");

  // Rounds past the last key would fall outside the bank.
  roundInRange: assert property (@(posedge clk) disable iff (!rstN)
    anyGnt |-> selAddr.round <= `AES_ROUNDS)
    else $error("Granted round %0d is out of range.", selAddr.round);

endmodule

// File: vlog.f
+incdir+include
verilog/aesPkg.sv
verilog/keyMemBus.sv
verilog/roundKeyStore.sv
verilog/keyScheduler.sv
verilog/invCipher.sv
verilog/invAesCore.sv
bench/tbClock.sv
bench/invAesTb.sv
